// File: cpu.f
+incdir+.
cpu_isa_pkg.sv
cpu_pipe_pkg.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_control.sv
cpu_execute.sv
cpu_writeback.sv
cpu_top.sv
tb_cpu.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f cpu.f --top-module tb_cpu -o tb_cpu \
	> build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/tb_cpu > sim.log 2>&1 || { echo "simulation aborted, see sim.log"; exit 1; }
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }

// File: tb_cpu_program.svh
`ifndef TB_CPU_PROGRAM_SVH
`define TB_CPU_PROGRAM_SVH

// reference model state
cpu_isa_pkg::word_t model_regs [cpu_isa_pkg::NUM_REGS];
cpu_isa_pkg::word_t model_mem [cpu_isa_pkg::word_t];
cpu_isa_pkg::word_t last_port;

function automatic cpu_isa_pkg::word_t rtype_word(cpu_isa_pkg::funct_e fn,
	cpu_isa_pkg::reg_idx_t rs, cpu_isa_pkg::reg_idx_t rt, cpu_isa_pkg::reg_idx_t rd);
	return {cpu_isa_pkg::OP_RTYPE, rs, rt, rd, fn};
endfunction

function automatic cpu_isa_pkg::word_t imm_word(cpu_isa_pkg::opcode_e op,
	cpu_isa_pkg::reg_idx_t rs, cpu_isa_pkg::reg_idx_t rt, logic [7:0] imm);
	return {op, rs, rt, imm};
endfunction

task model_execute(input cpu_isa_pkg::word_t w);
	logic [3:0]         op;
	logic [1:0]         rs;
	logic [1:0]         rt;
	logic [1:0]         rd;
	logic [5:0]         fn;
	logic [7:0]         imm;
	cpu_isa_pkg::word_t sext;
	cpu_isa_pkg::word_t addr;
	cpu_isa_pkg::word_t a;
	cpu_isa_pkg::word_t b;
	op = w[15:12];
	rs = w[11:10];
	rt = w[9:8];
	rd = w[7:6];
	fn = w[5:0];
	imm = w[7:0];
	sext = {{8{imm[7]}}, imm};
	a = model_regs[rs];
	b = model_regs[rt];
	addr = a + sext;
	case (op)
		cpu_isa_pkg::OP_ADI: model_regs[rt] = a + sext;
		cpu_isa_pkg::OP_ORI: model_regs[rt] = a | {8'h00, imm};
		cpu_isa_pkg::OP_LHI: model_regs[rt] = {imm, 8'h00};
		cpu_isa_pkg::OP_LWD: model_regs[rt] = model_mem.exists(addr) ? model_mem[addr]
			: fill_word(addr);
		cpu_isa_pkg::OP_SWD: begin
			model_mem[addr] = b;
			st_addr_exp[st_count] = addr;
			st_data_exp[st_count] = b;
			st_count++;
		end
		cpu_isa_pkg::OP_RTYPE: begin
			case (fn)
				cpu_isa_pkg::F_ADD: model_regs[rd] = a + b;
				cpu_isa_pkg::F_SUB: model_regs[rd] = a - b;
				cpu_isa_pkg::F_AND: model_regs[rd] = a & b;
				cpu_isa_pkg::F_ORR: model_regs[rd] = a | b;
				cpu_isa_pkg::F_NOT: model_regs[rd] = ~a;
				cpu_isa_pkg::F_TCP: model_regs[rd] = 16'd0 - a;
				cpu_isa_pkg::F_SHL: model_regs[rd] = {a[14:0], 1'b0};
				cpu_isa_pkg::F_SHR: model_regs[rd] = {a[15], a[15:1]};
				// only a changed value is visible on the port
				cpu_isa_pkg::F_WWD: begin
					if (a != last_port) begin
						wwd_exp[wwd_count] = a;
						wwd_count++;
						last_port = a;
					end
				end
				default: ;
			endcase
		end
		default: ;
	endcase
	inst_count++;
endtask

task emit(input cpu_isa_pkg::word_t w);
	imem[prog_len] = w;
	prog_len++;
	model_execute(w);
endtask

task build_program();
	logic [31:0]           r;
	cpu_isa_pkg::reg_idx_t a;
	cpu_isa_pkg::reg_idx_t b;
	cpu_isa_pkg::reg_idx_t c;
	cpu_isa_pkg::reg_idx_t d;
	cpu_isa_pkg::funct_e   fn;
	for (int i = 0; i < IMEM_DEPTH; i++) begin
		imem[i] = '0;
	end
	for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
		model_regs[i] = '0;
	end
	prog_len = 0;
	wwd_count = 0;
	st_count = 0;
	inst_count = '0;
	last_port = '0;
	// full 16-bit start value in every register
	for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
		r = next_rand();
		emit(imm_word(cpu_isa_pkg::OP_LHI, 2'd0, 2'(i), r[31:24]));
		emit(imm_word(cpu_isa_pkg::OP_ORI, 2'(i), 2'(i), r[23:16]));
	end
	for (int blk = 0; blk < NUM_BLOCKS; blk++) begin
		r = next_rand();
		a = r[23:22];
		b = r[21:20];
		c = r[19:18];
		d = r[17:16];
		fn = cpu_isa_pkg::funct_e'({3'b000, r[29:27]});
		case (r[31:30])
			2'd0: begin
				// back-to-back dependent ALU ops
				emit(rtype_word(fn, a, b, c));
				emit(rtype_word(cpu_isa_pkg::F_ADD, c, a, d));
				emit(imm_word(cpu_isa_pkg::OP_ADI, d, b, r[7:0]));
				emit(rtype_word(cpu_isa_pkg::F_WWD, b, 2'd0, 2'd0));
			end
			2'd1: begin
				// load then immediate use
				emit(imm_word(cpu_isa_pkg::OP_LWD, a, b, r[7:0]));
				emit(rtype_word(cpu_isa_pkg::F_ADD, b, c, d));
				emit(rtype_word(cpu_isa_pkg::F_WWD, d, 2'd0, 2'd0));
			end
			2'd2: begin
				emit(imm_word(cpu_isa_pkg::OP_SWD, a, b, r[7:0]));
				emit(imm_word(cpu_isa_pkg::OP_LWD, a, c, r[7:0]));
				emit(rtype_word(cpu_isa_pkg::F_WWD, c, 2'd0, 2'd0));
			end
			default: begin
				emit(imm_word(cpu_isa_pkg::OP_LHI, a, b, r[15:8]));
				emit(imm_word(cpu_isa_pkg::OP_ORI, b, c, r[7:0]));
				emit(rtype_word(fn, c, d, d));
				emit(rtype_word(cpu_isa_pkg::F_WWD, d, 2'd0, 2'd0));
			end
		endcase
	end
	emit(rtype_word(cpu_isa_pkg::F_HLT, 2'd0, 2'd0, 2'd0));
	program_ready = 1'b1;
endtask

`endif

// File: tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int IMEM_DEPTH   = 256;
	localparam int DMEM_DEPTH   = 65536;
	localparam int EXP_DEPTH    = 64;
	localparam int NUM_BLOCKS   = 20;

	logic                    clk = 1'b0;
	logic                    reset_n;
	cpu_pipe_pkg::imem_req_t imem_req;
	cpu_isa_pkg::word_t      imem_data;
	cpu_pipe_pkg::dmem_req_t dmem_req;
	cpu_isa_pkg::word_t      dmem_rdata;
	cpu_isa_pkg::word_t      num_inst;
	cpu_isa_pkg::word_t      output_port;
	logic                    is_halted;

	cpu_isa_pkg::word_t imem [IMEM_DEPTH];
	cpu_isa_pkg::word_t dmem [DMEM_DEPTH];

	// expected results from the reference model
	cpu_isa_pkg::word_t wwd_exp [EXP_DEPTH];
	cpu_isa_pkg::word_t st_addr_exp [EXP_DEPTH];
	cpu_isa_pkg::word_t st_data_exp [EXP_DEPTH];
	int                 wwd_count;
	int                 st_count;
	int                 prog_len;
	cpu_isa_pkg::word_t inst_count;
	logic               program_ready = 1'b0;
	logic [31:0]        lcg_state = 32'h945c_e733;

	// progress through the expected lists
	int                 wwd_idx;
	int                 st_idx;
	cpu_isa_pkg::word_t port_prev;
	logic               rst_seen = 1'b0;

	int reset_errors = 0;
	int port_errors = 0;
	int store_errors = 0;
	int halt_errors = 0;
	int total_errors;

	function logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// initial data memory contents, a function of the full address
	function automatic cpu_isa_pkg::word_t fill_word(cpu_isa_pkg::word_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'ha5c3;
	endfunction

	`include "tb_cpu_program.svh"

	cpu_top u_dut (
		.clk           (clk),
		.reset_n       (reset_n),
		.imem_o        (imem_req),
		.imem_data_i   (imem_data),
		.dmem_o        (dmem_req),
		.dmem_rdata_i  (dmem_rdata),
		.num_inst_o    (num_inst),
		.output_port_o (output_port),
		.is_halted_o   (is_halted)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// both memories answer in the same cycle
	assign imem_data = imem[imem_req.addr[7:0]];
	assign dmem_rdata = dmem[dmem_req.addr];

	always @(posedge clk) begin
		if (dmem_req.write) begin
			dmem[dmem_req.addr] <= dmem_req.wdata;
		end
	end

	always @(posedge clk) begin
		rst_seen <= !reset_n;
		if (!reset_n) begin
			wwd_idx <= 0;
			st_idx <= 0;
			port_prev <= '0;
		end else begin
			port_prev <= output_port;
			if (output_port != port_prev) begin
				wwd_idx <= wwd_idx + 1;
			end
			if (dmem_req.write) begin
				st_idx <= st_idx + 1;
			end
		end
	end

	// during reset and one cycle after
	a_reset_quiet: assert property (@(posedge clk)
		rst_seen |-> !dmem_req.read && !dmem_req.write && !is_halted && num_inst == '0
			&& !imem_req.read && imem_req.addr == '0 && output_port == '0)
	else begin
		reset_errors++;
		$display({"Error reset: expected dread 0 dwrite 0 halted 0 num_inst 0 iread 0 pc 0 ",
			"port 0, actual %b %b %b %0d %b %h %h"},
			$sampled(dmem_req.read), $sampled(dmem_req.write), $sampled(is_halted),
			$sampled(num_inst), $sampled(imem_req.read), $sampled(imem_req.addr),
			$sampled(output_port));
	end

	a_port_value: assert property (@(posedge clk) disable iff (!reset_n)
		(output_port != port_prev) |-> output_port == wwd_exp[wwd_idx])
	else begin
		port_errors++;
		$display("Error output port %0d: expected %h, actual %h", $sampled(wwd_idx),
			wwd_exp[$sampled(wwd_idx)], $sampled(output_port));
	end

	a_store_value: assert property (@(posedge clk) disable iff (!reset_n)
		dmem_req.write |-> dmem_req.addr == st_addr_exp[st_idx]
			&& dmem_req.wdata == st_data_exp[st_idx])
	else begin
		store_errors++;
		$display("Error store %0d: expected addr %h data %h, actual addr %h data %h",
			$sampled(st_idx), st_addr_exp[$sampled(st_idx)], st_data_exp[$sampled(st_idx)],
			$sampled(dmem_req.addr), $sampled(dmem_req.wdata));
	end

	a_halt_count: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(is_halted) |-> num_inst == inst_count)
	else begin
		halt_errors++;
		$display("Error halt count: expected %0d, actual %0d", inst_count, $sampled(num_inst));
	end

	a_after_halt: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted |-> !dmem_req.write && $stable(output_port))
	else begin
		halt_errors++;
		$display("store strobe or output port change seen after the processor halted");
	end

	a_results_complete: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(is_halted) |=> wwd_idx == wwd_count && st_idx == st_count)
	else begin
		halt_errors++;
		$display("processor halted before all expected outputs and stores were seen");
	end

	initial begin
		reset_n = 1'b0;
		for (int a = 0; a < DMEM_DEPTH; a++) begin
			dmem[a] = fill_word(16'(a));
		end
		build_program();
		repeat (RESET_CYCLES) @(posedge clk);
		#0.5;
		reset_n = 1'b1;
		wait (is_halted);
		// let the checks after halt run
		repeat (4) @(posedge clk);
		total_errors = reset_errors + port_errors + store_errors + halt_errors;
		$display("error counts: reset %0d, output port %0d, store %0d, halt %0d",
			reset_errors, port_errors, store_errors, halt_errors);
		if (total_errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// reset plus eight cycles per instruction
	initial begin
		wait (program_ready);
		#((RESET_CYCLES + 8 * prog_len) * CLK_PERIOD);
		$display("timeout: processor did not halt within %0d cycles",
			RESET_CYCLES + 8 * prog_len);
		$display("tests failed");
		$finish;
	end

endmodule

// File: cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
	input  logic                    clk,
	input  logic                    reset_n,
	output cpu_pipe_pkg::imem_req_t imem_o,
	input  cpu_isa_pkg::word_t      imem_data_i,
	output cpu_pipe_pkg::dmem_req_t dmem_o,
	input  cpu_isa_pkg::word_t      dmem_rdata_i,
	output cpu_isa_pkg::word_t      num_inst_o,
	output cpu_isa_pkg::word_t      output_port_o,
	output logic                    is_halted_o
);
	// decode stage
	cpu_isa_pkg::instr_t      id_instr;
	logic                     id_valid;
	cpu_pipe_pkg::ctrl_t      id_ctrl;
	logic                     stall;
	logic                     freeze;
	cpu_isa_pkg::word_t       rs_data;
	cpu_isa_pkg::word_t       rt_data;
	// execute and memory stages
	cpu_pipe_pkg::load_dest_t ex_load_dest;
	cpu_pipe_pkg::ctrl_t      mem_ctrl;
	cpu_isa_pkg::word_t       mem_result;
	cpu_isa_pkg::reg_idx_t    mem_dest_idx;
	cpu_isa_pkg::word_t       mem_out_val;
	// writeback
	cpu_pipe_pkg::dest_t      wb_dest;

	cpu_control u_control (
		.clk            (clk),
		.reset_n        (reset_n),
		.id_instr_i     (id_instr),
		.id_valid_i     (id_valid),
		.ex_load_dest_i (ex_load_dest),
		.id_ctrl_o      (id_ctrl),
		.stall_o        (stall),
		.freeze_o       (freeze)
	);

	cpu_fetch u_fetch (
		.clk         (clk),
		.reset_n     (reset_n),
		.stall_i     (stall),
		.freeze_i    (freeze),
		.imem_data_i (imem_data_i),
		.imem_o      (imem_o),
		.id_instr_o  (id_instr),
		.id_valid_o  (id_valid)
	);

	cpu_regfile u_regfile (
		.clk       (clk),
		.reset_n   (reset_n),
		.rs_i      (id_instr.rs),
		.rt_i      (id_instr.rt),
		.wb_dest_i (wb_dest),
		.rs_data_o (rs_data),
		.rt_data_o (rt_data)
	);

	cpu_execute u_execute (
		.clk            (clk),
		.reset_n        (reset_n),
		.id_ctrl_i      (id_ctrl),
		.id_instr_i     (id_instr),
		.rs_data_i      (rs_data),
		.rt_data_i      (rt_data),
		.wb_dest_i      (wb_dest),
		.ex_load_dest_o (ex_load_dest),
		.dmem_o         (dmem_o),
		.mem_ctrl_o     (mem_ctrl),
		.mem_result_o   (mem_result),
		.mem_dest_idx_o (mem_dest_idx),
		.mem_out_val_o  (mem_out_val)
	);

	cpu_writeback u_writeback (
		.clk            (clk),
		.reset_n        (reset_n),
		.mem_ctrl_i     (mem_ctrl),
		.mem_result_i   (mem_result),
		.mem_dest_idx_i (mem_dest_idx),
		.mem_out_val_i  (mem_out_val),
		.dmem_rdata_i   (dmem_rdata_i),
		.wb_dest_o      (wb_dest),
		.num_inst_o     (num_inst_o),
		.output_port_o  (output_port_o),
		.is_halted_o    (is_halted_o)
	);

endmodule

// File: cpu_writeback.sv
`timescale 1ns/100ps

module cpu_writeback (
	input  logic                  clk,
	input  logic                  reset_n,
	input  cpu_pipe_pkg::ctrl_t   mem_ctrl_i,
	input  cpu_isa_pkg::word_t    mem_result_i,
	input  cpu_isa_pkg::reg_idx_t mem_dest_idx_i,
	input  cpu_isa_pkg::word_t    mem_out_val_i,
	input  cpu_isa_pkg::word_t    dmem_rdata_i,
	output cpu_pipe_pkg::dest_t   wb_dest_o,
	output cpu_isa_pkg::word_t    num_inst_o,
	output cpu_isa_pkg::word_t    output_port_o,
	output logic                  is_halted_o
);
	cpu_pipe_pkg::ctrl_t   wb_ctrl_q;
	cpu_isa_pkg::word_t    wb_data_q;
	cpu_isa_pkg::word_t    wb_out_q;
	cpu_isa_pkg::reg_idx_t wb_idx_q;
	cpu_isa_pkg::word_t    num_inst_q;
	cpu_isa_pkg::word_t    port_q;
	logic                  halted_q;

	always_ff @(posedge clk) begin
		// load data arrives combinationally during memory stage
		wb_data_q <= mem_ctrl_i.mem_read ? dmem_rdata_i : mem_result_i;
		wb_out_q <= mem_out_val_i;
		wb_idx_q <= mem_dest_idx_i;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_ctrl_q <= cpu_pipe_pkg::ctrl_t'(0);
			num_inst_q <= '0;
			port_q <= '0;
			halted_q <= 1'b0;
		end else begin
			wb_ctrl_q <= mem_ctrl_i;
			// retire at the end of writeback
			if (wb_ctrl_q.valid) begin
				num_inst_q <= num_inst_q + 1'b1;
			end
			if (wb_ctrl_q.valid && wb_ctrl_q.wwd) begin
				port_q <= wb_out_q;
			end
			if (wb_ctrl_q.valid && wb_ctrl_q.halt) begin
				halted_q <= 1'b1;
			end
		end
	end

	assign wb_dest_o = '{we: wb_ctrl_q.valid && wb_ctrl_q.reg_write, idx: wb_idx_q, data: wb_data_q};
	assign num_inst_o = num_inst_q;
	assign output_port_o = port_q;
	assign is_halted_o = halted_q;

	// nothing behind HLT may retire
	a_halt_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		is_halted_o |=> $stable(num_inst_o));

endmodule

// File: cpu_execute.sv
`timescale 1ns/100ps

module cpu_execute (
	input  logic                     clk,
	input  logic                     reset_n,
	input  cpu_pipe_pkg::ctrl_t      id_ctrl_i,
	input  cpu_isa_pkg::instr_t      id_instr_i,
	input  cpu_isa_pkg::word_t       rs_data_i,
	input  cpu_isa_pkg::word_t       rt_data_i,
	input  cpu_pipe_pkg::dest_t      wb_dest_i,
	output cpu_pipe_pkg::load_dest_t ex_load_dest_o,
	output cpu_pipe_pkg::dmem_req_t  dmem_o,
	output cpu_pipe_pkg::ctrl_t      mem_ctrl_o,
	output cpu_isa_pkg::word_t       mem_result_o,
	output cpu_isa_pkg::reg_idx_t    mem_dest_idx_o,
	output cpu_isa_pkg::word_t       mem_out_val_o
);
	logic [cpu_isa_pkg::IMM_W-1:0] imm8;
	cpu_isa_pkg::word_t            id_imm;
	cpu_isa_pkg::reg_idx_t         id_dest;
	cpu_pipe_pkg::ctrl_t           ex_ctrl_q;
	cpu_isa_pkg::word_t            ex_rs_val_q, ex_rt_val_q, ex_imm_q;
	cpu_isa_pkg::reg_idx_t         ex_rs_q, ex_rt_q, ex_dest_q;
	logic                          mem_fwd_ok;
	cpu_pipe_pkg::fwd_sel_e        fwd_a, fwd_b;
	cpu_isa_pkg::word_t            op_a, op_rt, op_b, alu_y;
	cpu_pipe_pkg::ctrl_t           mem_ctrl_q;
	cpu_isa_pkg::word_t            mem_result_q, mem_store_q, mem_out_q;
	cpu_isa_pkg::reg_idx_t         mem_dest_q;

	function automatic cpu_isa_pkg::word_t fwd_mux(cpu_pipe_pkg::fwd_sel_e sel,
		cpu_isa_pkg::word_t reg_val, cpu_isa_pkg::word_t mem_val,
		cpu_isa_pkg::word_t wb_val);
		case (sel)
			cpu_pipe_pkg::FWD_MEM: return mem_val;
			cpu_pipe_pkg::FWD_WB:  return wb_val;
			default:               return reg_val;
		endcase
	endfunction

	// immediate extension, still in decode
	assign imm8 = id_instr_i[cpu_isa_pkg::IMM_W-1:0];
	always_comb begin
		case (id_instr_i.opcode)
			cpu_isa_pkg::OP_ORI: id_imm = {{cpu_isa_pkg::IMM_PAD{1'b0}}, imm8};
			cpu_isa_pkg::OP_LHI: id_imm = {imm8, {cpu_isa_pkg::IMM_PAD{1'b0}}};
			default:             id_imm = {{cpu_isa_pkg::IMM_PAD{imm8[cpu_isa_pkg::IMM_W-1]}}, imm8};
		endcase
	end

	// rd for R-type, rt for the rest
	assign id_dest = (id_instr_i.opcode == cpu_isa_pkg::OP_RTYPE) ? id_instr_i.rd : id_instr_i.rt;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			ex_ctrl_q <= cpu_pipe_pkg::ctrl_t'(0);
			mem_ctrl_q <= cpu_pipe_pkg::ctrl_t'(0);
		end else begin
			ex_ctrl_q <= id_ctrl_i;
			mem_ctrl_q <= ex_ctrl_q;
		end
	end

	always_ff @(posedge clk) begin
		ex_rs_val_q <= rs_data_i;
		ex_rt_val_q <= rt_data_i;
		ex_imm_q <= id_imm;
		ex_rs_q <= id_instr_i.rs;
		ex_rt_q <= id_instr_i.rt;
		ex_dest_q <= id_dest;
		mem_result_q <= alu_y;
		mem_store_q <= op_rt;
		mem_out_q <= op_a;
		mem_dest_q <= ex_dest_q;
	end

	// a load in memory stage has no data yet; the stall keeps it from being needed
	assign mem_fwd_ok = mem_ctrl_q.valid && mem_ctrl_q.reg_write && !mem_ctrl_q.mem_read;
	assign fwd_a = (mem_fwd_ok && mem_dest_q == ex_rs_q) ? cpu_pipe_pkg::FWD_MEM
		: (wb_dest_i.we && wb_dest_i.idx == ex_rs_q) ? cpu_pipe_pkg::FWD_WB : cpu_pipe_pkg::FWD_REG;
	assign fwd_b = (mem_fwd_ok && mem_dest_q == ex_rt_q) ? cpu_pipe_pkg::FWD_MEM
		: (wb_dest_i.we && wb_dest_i.idx == ex_rt_q) ? cpu_pipe_pkg::FWD_WB : cpu_pipe_pkg::FWD_REG;

	assign op_a = fwd_mux(fwd_a, ex_rs_val_q, mem_result_q, wb_dest_i.data);
	assign op_rt = fwd_mux(fwd_b, ex_rt_val_q, mem_result_q, wb_dest_i.data);
	assign op_b = ex_ctrl_q.alu_src_imm ? ex_imm_q : op_rt;

	always_comb begin
		case (ex_ctrl_q.alu_op)
			cpu_pipe_pkg::ALU_ADD: alu_y = op_a + op_b;
			cpu_pipe_pkg::ALU_SUB: alu_y = op_a - op_b;
			cpu_pipe_pkg::ALU_AND: alu_y = op_a & op_b;
			cpu_pipe_pkg::ALU_ORR: alu_y = op_a | op_b;
			cpu_pipe_pkg::ALU_NOT: alu_y = ~op_a;
			cpu_pipe_pkg::ALU_TCP: alu_y = ~op_a + 1'b1;
			cpu_pipe_pkg::ALU_SHL: alu_y = op_a << 1;
			// arithmetic shift keeps the sign
			cpu_pipe_pkg::ALU_SHR: alu_y = {op_a[cpu_isa_pkg::WORD_W-1], op_a[cpu_isa_pkg::WORD_W-1:1]};
			default:               alu_y = op_b;
		endcase
	end

	assign ex_load_dest_o = '{load: ex_ctrl_q.valid && ex_ctrl_q.mem_read, idx: ex_dest_q};
	assign dmem_o = '{read: mem_ctrl_q.valid && mem_ctrl_q.mem_read,
		write: mem_ctrl_q.valid && mem_ctrl_q.mem_write, addr: mem_result_q, wdata: mem_store_q};
	assign mem_ctrl_o = mem_ctrl_q;
	assign mem_result_o = mem_result_q;
	assign mem_dest_idx_o = mem_dest_q;
	assign mem_out_val_o = mem_out_q;

	a_dmem_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		!(dmem_o.read && dmem_o.write));

endmodule

// File: cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
	input  logic                     clk,
	input  logic                     reset_n,
	input  cpu_isa_pkg::instr_t      id_instr_i,
	input  logic                     id_valid_i,
	input  cpu_pipe_pkg::load_dest_t ex_load_dest_i,
	output cpu_pipe_pkg::ctrl_t      id_ctrl_o,
	output logic                     stall_o,
	output logic                     freeze_o
);
	cpu_pipe_pkg::ctrl_t dec;
	logic                reads_rs;
	logic                reads_rt;
	logic                rs_hit;
	logic                rt_hit;
	logic                freeze_q;

	always_comb begin
		dec = cpu_pipe_pkg::ctrl_t'(0);
		dec.alu_op = cpu_pipe_pkg::ALU_ADD;
		reads_rs = 1'b0;
		reads_rt = 1'b0;
		case (id_instr_i.opcode)
			cpu_isa_pkg::OP_ADI: begin
				dec = '{alu_op: cpu_pipe_pkg::ALU_ADD, alu_src_imm: 1'b1, reg_write: 1'b1,
					valid: 1'b1, default: 1'b0};
				reads_rs = 1'b1;
			end
			cpu_isa_pkg::OP_ORI: begin
				dec = '{alu_op: cpu_pipe_pkg::ALU_ORR, alu_src_imm: 1'b1, reg_write: 1'b1,
					valid: 1'b1, default: 1'b0};
				reads_rs = 1'b1;
			end
			cpu_isa_pkg::OP_LHI: begin
				dec = '{alu_op: cpu_pipe_pkg::ALU_PASS, alu_src_imm: 1'b1, reg_write: 1'b1,
					valid: 1'b1, default: 1'b0};
			end
			// address is rs plus offset for both memory ops
			cpu_isa_pkg::OP_LWD: begin
				dec = '{alu_op: cpu_pipe_pkg::ALU_ADD, alu_src_imm: 1'b1, mem_read: 1'b1,
					reg_write: 1'b1, valid: 1'b1, default: 1'b0};
				reads_rs = 1'b1;
			end
			cpu_isa_pkg::OP_SWD: begin
				dec = '{alu_op: cpu_pipe_pkg::ALU_ADD, alu_src_imm: 1'b1, mem_write: 1'b1,
					valid: 1'b1, default: 1'b0};
				reads_rs = 1'b1;
				reads_rt = 1'b1;
			end
			cpu_isa_pkg::OP_RTYPE: begin
				case (id_instr_i.funct)
					cpu_isa_pkg::F_ADD, cpu_isa_pkg::F_SUB, cpu_isa_pkg::F_AND,
					cpu_isa_pkg::F_ORR, cpu_isa_pkg::F_NOT, cpu_isa_pkg::F_TCP,
					cpu_isa_pkg::F_SHL, cpu_isa_pkg::F_SHR: begin
						dec.alu_op = cpu_pipe_pkg::alu_op_e'(
							id_instr_i[cpu_pipe_pkg::ALU_OP_W-1:0]);
						dec.reg_write = 1'b1;
						dec.valid = 1'b1;
						reads_rs = 1'b1;
						// unary ops ignore rt
						reads_rt = id_instr_i.funct inside {cpu_isa_pkg::F_ADD,
							cpu_isa_pkg::F_SUB, cpu_isa_pkg::F_AND, cpu_isa_pkg::F_ORR};
					end
					cpu_isa_pkg::F_WWD: begin
						dec.wwd = 1'b1;
						dec.valid = 1'b1;
						reads_rs = 1'b1;
					end
					cpu_isa_pkg::F_HLT: begin
						dec.halt = 1'b1;
						dec.valid = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	// load in execute feeding a register this instruction reads
	assign rs_hit = reads_rs && (id_instr_i.rs == ex_load_dest_i.idx);
	assign rt_hit = reads_rt && (id_instr_i.rt == ex_load_dest_i.idx);
	assign stall_o = id_valid_i && ex_load_dest_i.load && (rs_hit || rt_hit);

	assign id_ctrl_o = (id_valid_i && !stall_o) ? dec : cpu_pipe_pkg::ctrl_t'(0);

	// fetch stops in the same cycle HLT is decoded
	assign freeze_o = freeze_q || id_ctrl_o.halt;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			freeze_q <= 1'b0;
		end else if (id_ctrl_o.halt) begin
			freeze_q <= 1'b1;
		end
	end

	a_no_valid_bubble: assert property (@(posedge clk) disable iff (!reset_n)
		stall_o |-> !id_ctrl_o.valid);

	// the bubble clears the load from execute, so a stall never lasts two cycles
	a_single_stall: assert property (@(posedge clk) disable iff (!reset_n)
		stall_o |=> !stall_o);

endmodule

// File: cpu_fetch.sv
`timescale 1ns/100ps

module cpu_fetch (
	input  logic                    clk,
	input  logic                    reset_n,
	input  logic                    stall_i,
	input  logic                    freeze_i,
	input  cpu_isa_pkg::word_t      imem_data_i,
	output cpu_pipe_pkg::imem_req_t imem_o,
	output cpu_isa_pkg::instr_t     id_instr_o,
	output logic                    id_valid_o
);
	cpu_isa_pkg::word_t  pc_q;
	logic                run_q;
	logic                fetch_go;
	cpu_isa_pkg::instr_t id_instr_q;
	logic                id_valid_q;

	// first fetch one cycle out of reset
	assign fetch_go = run_q && !stall_i && !freeze_i;
	assign imem_o = '{read: fetch_go, addr: pc_q};

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc_q <= '0;
			run_q <= 1'b0;
			id_valid_q <= 1'b0;
		end else begin
			run_q <= 1'b1;
			if (fetch_go) begin
				pc_q <= pc_q + 1'b1;
			end
			// hold on stall, drop on freeze
			if (freeze_i || !stall_i) begin
				id_valid_q <= fetch_go;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_go) begin
			id_instr_q <= cpu_isa_pkg::instr_t'(imem_data_i);
		end
	end

	assign id_instr_o = id_instr_q;
	assign id_valid_o = id_valid_q;

	a_pc_hold: assert property (@(posedge clk) disable iff (!reset_n)
		stall_i |=> $stable(pc_q));

endmodule

// File: cpu_regfile.sv
`timescale 1ns/100ps

module cpu_regfile (
	input  logic                  clk,
	input  logic                  reset_n,
	input  cpu_isa_pkg::reg_idx_t rs_i,
	input  cpu_isa_pkg::reg_idx_t rt_i,
	input  cpu_pipe_pkg::dest_t   wb_dest_i,
	output cpu_isa_pkg::word_t    rs_data_o,
	output cpu_isa_pkg::word_t    rt_data_o
);
	cpu_isa_pkg::word_t regs [cpu_isa_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < cpu_isa_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_dest_i.we) begin
			regs[wb_dest_i.idx] <= wb_dest_i.data;
		end
	end

	// writeback in the same cycle wins over the stored value
	assign rs_data_o = (wb_dest_i.we && wb_dest_i.idx == rs_i) ? wb_dest_i.data
		: regs[rs_i];
	assign rt_data_o = (wb_dest_i.we && wb_dest_i.idx == rt_i) ? wb_dest_i.data
		: regs[rt_i];

endmodule

// File: cpu_pipe_pkg.sv
package cpu_pipe_pkg;

	localparam int ALU_OP_W = 4;
	localparam int FWD_W    = 2;

	// first eight codes line up with the R-type function codes
	typedef enum logic [ALU_OP_W-1:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_ORR  = 4'd3,
		ALU_NOT  = 4'd4,
		ALU_TCP  = 4'd5,
		ALU_SHL  = 4'd6,
		ALU_SHR  = 4'd7,
		ALU_PASS = 4'd8
	} alu_op_e;

	typedef enum logic [FWD_W-1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

	// all fields zero for a bubble
	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    wwd;
		logic    halt;
		logic    valid;
	} ctrl_t;

	// result on its way into the register file
	typedef struct packed {
		logic                  we;
		cpu_isa_pkg::reg_idx_t idx;
		cpu_isa_pkg::word_t    data;
	} dest_t;

	typedef struct packed {
		logic                  load;
		cpu_isa_pkg::reg_idx_t idx;
	} load_dest_t;

	typedef struct packed {
		logic               read;
		logic               write;
		cpu_isa_pkg::word_t addr;
		cpu_isa_pkg::word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		logic               read;
		cpu_isa_pkg::word_t addr;
	} imem_req_t;

endpackage

// File: cpu_isa_pkg.sv
package cpu_isa_pkg;

	localparam int WORD_W   = 16;
	localparam int NUM_REGS = 4;
	localparam int REG_W    = $clog2(NUM_REGS);
	localparam int IMM_W    = 8;
	// bits above the immediate after extension
	localparam int IMM_PAD  = WORD_W - IMM_W;
	localparam int OPCODE_W = 4;
	localparam int FUNCT_W  = 6;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [REG_W-1:0]  reg_idx_t;

	typedef enum logic [OPCODE_W-1:0] {
		OP_ADI   = 4'd4,
		OP_ORI   = 4'd5,
		OP_LHI   = 4'd6,
		OP_LWD   = 4'd7,
		OP_SWD   = 4'd8,
		OP_RTYPE = 4'd15
	} opcode_e;

	// only meaningful with OP_RTYPE
	typedef enum logic [FUNCT_W-1:0] {
		F_ADD = 6'd0,
		F_SUB = 6'd1,
		F_AND = 6'd2,
		F_ORR = 6'd3,
		F_NOT = 6'd4,
		F_TCP = 6'd5,
		F_SHL = 6'd6,
		F_SHR = 6'd7,
		F_WWD = 6'd28,
		F_HLT = 6'd29
	} funct_e;

	// immediate overlays rd and funct in the low eight bits
	typedef struct packed {
		opcode_e  opcode;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		funct_e   funct;
	} instr_t;

endpackage
